// ==== logic/seg_decode.sv ====
module seg_decode import tu_pkg::*; (
    input  word_t i_vaddr,
    input  logic  i_k0_uncached,
    output logic  o_mapped,
    output word_t o_paddr,
    output logic  o_uncached
);

    logic is_useg;
    logic is_kseg0;
    logic is_kseg1;
    logic is_kseg23;

    // Segment classification from the top address bits.
    assign is_useg   = ~i_vaddr[31];
    assign is_kseg0  = i_vaddr[31:29] == SEG_KSEG0;
    assign is_kseg1  = i_vaddr[31:29] == SEG_KSEG1;
    assign is_kseg23 = i_vaddr[31:30] == 2'b11;

    assign o_mapped = is_useg | is_kseg23;  // Goes through the TLB.

    // kseg0 and kseg1 both fold onto the low 512 MiB.
    assign o_paddr = {3'b000, i_vaddr[28:0]};

    assign o_uncached = is_kseg1 | (is_kseg0 & i_k0_uncached);

endmodule

// ==== logic/tlb_lookup.sv ====
module tlb_lookup import tu_pkg::*; (
    input  tlb_table_t        i_table,
    input  word_t             i_vaddr,
    input  logic [ASID_W-1:0] i_asid,
    output tlb_lookup_t       o_res
);

    logic [TLB_ENTRIES-1:0] match;
    tlb_idx_t               hit_idx;
    tlb_entry_t             sel;
    logic                   odd;

    // Page number and address space compare, G overrides ASID.
    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_match
        assign match[i] = (i_table[i].vpn2 == i_vaddr[31:32-VPN2_W]) &&
                          (i_table[i].G || (i_table[i].asid == i_asid));
    end

    // Lowest matching index wins.
    always_comb begin
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = tlb_idx_t'(i);
            end
        end
    end

    assign sel = i_table[hit_idx];  // Entry 0 on a miss.
    assign odd = i_vaddr[12];

    assign o_res.tlb_idx = hit_idx;
    assign o_res.hit     = |match;
    assign o_res.pfn     = odd ? sel.pfn1 : sel.pfn0;
    assign o_res.C       = odd ? sel.C1 : sel.C0;
    assign o_res.D       = odd ? sel.D1 : sel.D0;
    assign o_res.V       = odd ? sel.V1 : sel.V0;

endmodule

// ==== logic/tlb_table.sv ====
module tlb_table import tu_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  tlb_write_t i_wr,
    input  tlb_idx_t   i_rd_idx,
    output tlb_table_t o_table,
    output tlb_entry_t o_rd_entry
);

    tlb_table_t entries;

    // One register bank per entry, written only when addressed.
    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        always_ff @(posedge clk) begin
            if (!resetn) begin
                entries[i] <= '0;  // Clears vpn2, ASID and G too.
            end else if (i_wr.valid && (i_wr.addr == tlb_idx_t'(i))) begin
                entries[i] <= i_wr.data;
            end
        end
    end

    assign o_table    = entries;
    assign o_rd_entry = entries[i_rd_idx];  // TLBR port.

    // A written entry feeds every lookup on the next cycle.
    a_wr_data_known: assert property (
        @(posedge clk) disable iff (!resetn)
        i_wr.valid |-> !$isunknown(i_wr.data)
    ) else $error("tlb_table: unknown bits in TLB write data");

endmodule

// ==== logic/translation_unit.sv ====
module translation_unit import tu_pkg::*; (
    input  logic          clk,
    input  logic          resetn,
    input  logic          i_k0_uncached,
    input  tu_addr_req_t  i_ireq,
    input  tu_addr_req_t  i_dreq,
    input  tu_op_req_t    i_op_req,
    output tu_addr_resp_t o_iresp,
    output tu_addr_resp_t o_dresp,
    output tu_op_resp_t   o_op_resp
);

    logic        i_mapped;
    logic        d_mapped;
    word_t       i_seg_paddr;
    word_t       d_seg_paddr;
    logic        i_seg_uncached;
    logic        d_seg_uncached;
    tlb_write_t  wr;
    tlb_table_t  table_q;
    tlb_entry_t  rd_entry;
    tlb_lookup_t i_res;
    tlb_lookup_t d_res;
    tlb_lookup_t p_res;

    // Picks the TLB or the fixed segment translation for one port.
    function automatic tu_addr_resp_t merge_resp(
        input logic        mapped,
        input word_t       vaddr,
        input word_t       seg_paddr,
        input logic        seg_uncached,
        input tlb_lookup_t res
    );
        tu_addr_resp_t resp;
        resp.mapped = mapped;
        if (mapped) begin
            resp.paddr       = {res.pfn, vaddr[11:0]};
            resp.is_uncached = res.C == CACHE_UNCACHED;
            resp.miss        = ~res.hit;
            resp.invalid     = res.hit & ~res.V;
            resp.dirty       = res.D;
        end else begin
            resp.paddr       = seg_paddr;
            resp.is_uncached = seg_uncached;
            resp.miss        = 1'b0;
            resp.invalid     = 1'b0;
            resp.dirty       = 1'b0;
        end
        return resp;
    endfunction

    seg_decode u_iseg (
        .i_vaddr       (i_ireq.vaddr),
        .i_k0_uncached (i_k0_uncached),
        .o_mapped      (i_mapped),
        .o_paddr       (i_seg_paddr),
        .o_uncached    (i_seg_uncached)
    );

    seg_decode u_dseg (
        .i_vaddr       (i_dreq.vaddr),
        .i_k0_uncached (i_k0_uncached),
        .o_mapped      (d_mapped),
        .o_paddr       (d_seg_paddr),
        .o_uncached    (d_seg_uncached)
    );

    // TLBWI record, global only if both halves are global.
    always_comb begin
        wr.valid     = i_op_req.is_tlbwi;
        wr.addr      = i_op_req.index.index;
        wr.data.vpn2 = i_op_req.entryhi.vpn2;
        wr.data.asid = i_op_req.entryhi.asid;
        wr.data.G    = i_op_req.entrylo0.G & i_op_req.entrylo1.G;
        wr.data.pfn0 = i_op_req.entrylo0.pfn;
        wr.data.pfn1 = i_op_req.entrylo1.pfn;
        wr.data.C0   = i_op_req.entrylo0.C;
        wr.data.C1   = i_op_req.entrylo1.C;
        wr.data.D0   = i_op_req.entrylo0.D;
        wr.data.D1   = i_op_req.entrylo1.D;
        wr.data.V0   = i_op_req.entrylo0.V;
        wr.data.V1   = i_op_req.entrylo1.V;
    end

    tlb_table u_table (
        .clk        (clk),
        .resetn     (resetn),
        .i_wr       (wr),
        .i_rd_idx   (i_op_req.index.index),
        .o_table    (table_q),
        .o_rd_entry (rd_entry)
    );

    tlb_lookup u_ilut (
        .i_table (table_q),
        .i_vaddr (i_ireq.vaddr),
        .i_asid  (i_op_req.entryhi.asid),
        .o_res   (i_res)
    );

    tlb_lookup u_dlut (
        .i_table (table_q),
        .i_vaddr (i_dreq.vaddr),
        .i_asid  (i_op_req.entryhi.asid),
        .o_res   (d_res)
    );

    // Probe uses EntryHi itself as the address.
    tlb_lookup u_plut (
        .i_table (table_q),
        .i_vaddr (word_t'(i_op_req.entryhi)),
        .i_asid  (i_op_req.entryhi.asid),
        .o_res   (p_res)
    );

    assign o_iresp = merge_resp(i_mapped, i_ireq.vaddr, i_seg_paddr, i_seg_uncached, i_res);
    assign o_dresp = merge_resp(d_mapped, i_dreq.vaddr, d_seg_paddr, d_seg_uncached, d_res);

    always_comb begin
        o_op_resp.index.P        = ~p_res.hit;
        o_op_resp.index.zero     = '0;
        o_op_resp.index.index    = p_res.tlb_idx;
        o_op_resp.entryhi.vpn2   = rd_entry.vpn2;
        o_op_resp.entryhi.zero   = '0;
        o_op_resp.entryhi.asid   = rd_entry.asid;
        o_op_resp.entrylo0.fill  = '0;
        o_op_resp.entrylo0.pfn   = rd_entry.pfn0;
        o_op_resp.entrylo0.C     = rd_entry.C0;
        o_op_resp.entrylo0.D     = rd_entry.D0;
        o_op_resp.entrylo0.V     = rd_entry.V0;
        o_op_resp.entrylo0.G     = 1'b0;  // Global reads back on EntryLo1 only.
        o_op_resp.entrylo1.fill  = '0;
        o_op_resp.entrylo1.pfn   = rd_entry.pfn1;
        o_op_resp.entrylo1.C     = rd_entry.C1;
        o_op_resp.entrylo1.D     = rd_entry.D1;
        o_op_resp.entrylo1.V     = rd_entry.V1;
        o_op_resp.entrylo1.G     = rd_entry.G;
    end

    // CP0 issues one TLB operation at a time.
    a_op_onehot: assert property (
        @(posedge clk) disable iff (!resetn)
        !(i_op_req.is_tlbwi && i_op_req.is_tlbp)
    ) else $error("translation_unit: TLBWI and TLBP requested together");

endmodule

// ==== logic/tu_pkg.sv ====
package tu_pkg;

    // TLB geometry.
    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);

    // Field widths of the MIPS32 CP0 images.
    localparam int VPN2_W = 19;
    localparam int ASID_W = 8;
    localparam int PFN_W  = 20;

    // Cache attribute value that means uncached.
    localparam logic [2:0] CACHE_UNCACHED = 3'd2;

    // Top three address bits of the unmapped kernel segments.
    localparam logic [2:0] SEG_KSEG0 = 3'b100;
    localparam logic [2:0] SEG_KSEG1 = 3'b101;

    typedef logic [31:0]          word_t;
    typedef logic [TLB_IDX_W-1:0] tlb_idx_t;

    typedef struct packed {
        logic [VPN2_W-1:0]        vpn2;
        logic [31-VPN2_W-ASID_W:0] zero;
        logic [ASID_W-1:0]        asid;  // Current address space.
    } cp0_entryhi_t;

    typedef struct packed {
        logic [31-PFN_W-6:0] fill;
        logic [PFN_W-1:0]    pfn;
        logic [2:0]          C;
        logic                D;  // Page writable.
        logic                V;
        logic                G;
    } cp0_entrylo_t;

    typedef struct packed {
        logic                   P;  // Set on probe failure.
        logic [30-TLB_IDX_W:0]  zero;
        tlb_idx_t               index;
    } cp0_index_t;

    // One dual-page TLB entry.
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              G;
        logic [PFN_W-1:0]  pfn0;  // Even page.
        logic [PFN_W-1:0]  pfn1;  // Odd page.
        logic [2:0]        C0;
        logic [2:0]        C1;
        logic              D0;
        logic              D1;
        logic              V0;
        logic              V1;
    } tlb_entry_t;

    typedef tlb_entry_t [TLB_ENTRIES-1:0] tlb_table_t;

    typedef struct packed {
        logic       valid;
        tlb_idx_t   addr;
        tlb_entry_t data;
    } tlb_write_t;

    typedef struct packed {
        word_t vaddr;
    } tu_addr_req_t;

    typedef struct packed {
        word_t paddr;
        logic  is_uncached;
        logic  mapped;
        logic  miss;     // No entry matched.
        logic  invalid;  // Matched, but V clear.
        logic  dirty;
    } tu_addr_resp_t;

    typedef struct packed {
        logic         is_tlbwi;
        logic         is_tlbp;
        cp0_index_t   index;
        cp0_entryhi_t entryhi;
        cp0_entrylo_t entrylo0;
        cp0_entrylo_t entrylo1;
    } tu_op_req_t;

    typedef struct packed {
        cp0_index_t   index;     // Probe result.
        cp0_entryhi_t entryhi;   // TLBR read back.
        cp0_entrylo_t entrylo0;
        cp0_entrylo_t entrylo1;
    } tu_op_resp_t;

    typedef struct packed {
        tlb_idx_t         tlb_idx;
        logic             hit;
        logic [PFN_W-1:0] pfn;
        logic [2:0]       C;
        logic             D;
        logic             V;
    } tlb_lookup_t;

endpackage

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -f vlog.f --top-module tu_tb -o tu_sim &&
./obj_dir/tu_sim | tee /dev/stderr | grep -q "^TEST PASSED$" &&
echo "simulation ok" ||
{ echo "simulation failed"; exit 1; }

// ==== verif/tu_tests.svh ====
// Model table, held as the images that TLBR returns.
cp0_entryhi_t model_hi  [TLB_ENTRIES];
cp0_entrylo_t model_lo0 [TLB_ENTRIES];
cp0_entrylo_t model_lo1 [TLB_ENTRIES];  // G here is the entry's global bit.

task automatic report_mismatch(input string test, input logic [63:0] expected,
                               input logic [63:0] actual);
    $display("MISMATCH %s: expected %h, actual %h", test, expected, actual);
    mismatches++;
endtask

task automatic report_failure(input string what);
    $display("ERROR: %s", what);
    failures++;
endtask

function automatic void model_clear();
    for (int i = 0; i < TLB_ENTRIES; i++) begin
        model_hi[i]  = '0;
        model_lo0[i] = '0;
        model_lo1[i] = '0;
    end
endfunction

// First matching entry, -1 on a miss.
function automatic int model_match(input logic [18:0] vpn2, input logic [7:0] asid);
    int idx;
    idx = -1;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
        if (idx < 0 && model_hi[i].vpn2 == vpn2 &&
            (model_lo1[i].G || model_hi[i].asid == asid)) begin
            idx = i;
        end
    end
    return idx;
endfunction

function automatic tu_addr_resp_t expect_resp(input word_t vaddr, input logic [7:0] asid,
                                              input logic k0);
    tu_addr_resp_t r;
    cp0_entrylo_t  lo;
    int            idx;
    int            sel;
    r = '0;
    if (vaddr[31:30] == 2'b10) begin
        r.paddr       = vaddr & 32'h1fff_ffff;
        r.is_uncached = vaddr[29] | k0;  // kseg1 or uncached kseg0.
    end else begin
        idx           = model_match(vaddr[31:13], asid);
        sel           = (idx < 0) ? 0 : idx;  // Entry 0 on a miss.
        lo            = vaddr[12] ? model_lo1[sel] : model_lo0[sel];
        r.mapped      = 1'b1;
        r.paddr       = {lo.pfn, vaddr[11:0]};
        r.is_uncached = lo.C == 3'd2;
        r.miss        = idx < 0;
        r.invalid     = idx >= 0 && !lo.V;
        r.dirty       = lo.D;
    end
    return r;
endfunction

task automatic tlb_write(input int idx, input cp0_entryhi_t hi, input cp0_entrylo_t lo0,
                         input cp0_entrylo_t lo1);
    @(negedge clk);
    op_req.is_tlbwi    = 1'b1;
    op_req.index.index = tlb_idx_t'(idx);
    op_req.entryhi     = hi;
    op_req.entrylo0    = lo0;
    op_req.entrylo1    = lo1;
    @(negedge clk);
    op_req.is_tlbwi = 1'b0;
    model_hi[idx]   = {hi.vpn2, 5'b0, hi.asid};
    model_lo0[idx]  = {6'b0, lo0.pfn, lo0.C, lo0.D, lo0.V, 1'b0};
    model_lo1[idx]  = {6'b0, lo1.pfn, lo1.C, lo1.D, lo1.V, lo0.G & lo1.G};
endtask

task automatic read_check(input string test, input int idx);
    @(negedge clk);
    op_req.index.index = tlb_idx_t'(idx);
    #1;
    if (op_resp.entryhi !== model_hi[idx]) begin
        report_mismatch({test, " entryhi"}, 64'(model_hi[idx]), 64'(op_resp.entryhi));
    end
    if (op_resp.entrylo0 !== model_lo0[idx]) begin
        report_mismatch({test, " entrylo0"}, 64'(model_lo0[idx]), 64'(op_resp.entrylo0));
    end
    if (op_resp.entrylo1 !== model_lo1[idx]) begin
        report_mismatch({test, " entrylo1"}, 64'(model_lo1[idx]), 64'(op_resp.entrylo1));
    end
endtask

task automatic probe_check(input string test, input cp0_entryhi_t hi);
    int idx;
    @(negedge clk);
    op_req.is_tlbp = 1'b1;
    op_req.entryhi = hi;
    #1;
    idx = model_match(hi.vpn2, hi.asid);
    if (op_resp.index.P !== (idx < 0)) begin
        report_mismatch({test, " P"}, 64'(idx < 0), 64'(op_resp.index.P));
    end
    if (op_resp.index.zero !== '0) begin
        report_mismatch({test, " index zero"}, 64'(0), 64'(op_resp.index.zero));
    end
    if (idx >= 0 && op_resp.index.index !== tlb_idx_t'(idx)) begin
        report_mismatch({test, " index"}, 64'(idx), 64'(op_resp.index.index));
    end
    op_req.is_tlbp = 1'b0;
endtask

task automatic translate_check(input string test, input word_t iv, input word_t dv,
                               input logic [7:0] asid, input logic k0);
    tu_addr_resp_t exp_i;
    tu_addr_resp_t exp_d;
    @(negedge clk);
    k0_uncached         = k0;
    ireq.vaddr          = iv;
    dreq.vaddr          = dv;
    op_req.entryhi.asid = asid;  // Current address space.
    #1;
    exp_i = expect_resp(iv, asid, k0);
    exp_d = expect_resp(dv, asid, k0);
    if ($isunknown(iresp) || $isunknown(dresp)) begin
        report_failure({test, ": unknown bits on a translation response"});
    end
    if (iresp !== exp_i) begin
        report_mismatch({test, " iport"}, 64'(exp_i), 64'(iresp));
    end
    if (dresp !== exp_d) begin
        report_mismatch({test, " dport"}, 64'(exp_d), 64'(dresp));
    end
endtask

task automatic test_reset_state();
    cp0_entryhi_t hi;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
        read_check($sformatf("reset_read_%0d", i), i);
    end
    hi = '0;
    probe_check("reset_probe_zero", hi);
    hi.vpn2 = 19'h1_2345;
    probe_check("reset_probe_miss", hi);
endtask

task automatic test_unmapped();
    word_t iv;
    word_t dv;
    for (int n = 0; n < 50; n++) begin
        iv        = $random(seed);
        dv        = $random(seed);
        iv[31:30] = 2'b10;  // kseg0 or kseg1.
        dv[31:30] = 2'b10;
        translate_check("unmapped", iv, dv, 8'h00, n[0]);
    end
endtask

task automatic test_write_read();
    cp0_entryhi_t hi;
    cp0_entrylo_t lo0;
    cp0_entrylo_t lo1;
    hi     = cp0_entryhi_t'($random(seed));  // Reserved bits read back as zero.
    lo0    = cp0_entrylo_t'($random(seed));
    lo1    = cp0_entrylo_t'($random(seed));
    lo0.G  = 1'b1;
    lo1.G  = 1'b1;
    tlb_write(3, hi, lo0, lo1);
    hi     = cp0_entryhi_t'($random(seed));
    lo0    = cp0_entrylo_t'($random(seed));
    lo1    = cp0_entrylo_t'($random(seed));
    lo0.G  = 1'b1;
    lo1.G  = 1'b0;
    tlb_write(9, hi, lo0, lo1);
    lo0.G  = 1'b0;
    lo1.G  = 1'b1;
    tlb_write(12, hi, lo0, lo1);
    read_check("tlbr_global", 3);
    read_check("tlbr_local", 9);
    read_check("tlbr_local_lo1", 12);
    read_check("tlbr_untouched", 4);
endtask

task automatic test_mapped();
    word_t iv;
    word_t dv;
    // Useg pages at 0x0040_0000, odd page uncached.
    tlb_write(5, {19'h00200, 5'd0, 8'h11}, {6'd0, 20'h12345, 3'd3, 1'b1, 1'b1, 1'b0},
              {6'd0, 20'h6789a, 3'd2, 1'b0, 1'b1, 1'b0});
    // Global kseg2 pages, even page invalid.
    tlb_write(6, {19'h60001, 5'd0, 8'h22}, {6'd0, 20'hab000, 3'd3, 1'b0, 1'b0, 1'b1},
              {6'd0, 20'hcd111, 3'd3, 1'b1, 1'b1, 1'b1});
    translate_check("even_odd", 32'h0040_0123, 32'h0040_1abc, 8'h11, 1'b0);
    translate_check("asid_miss", 32'h0040_0123, 32'h0040_1abc, 8'h33, 1'b0);
    translate_check("global_invalid", 32'hc000_2010, 32'hc000_3ffc, 8'h33, 1'b0);
    for (int n = 0; n < 20; n++) begin
        iv     = $random(seed);
        dv     = $random(seed);
        iv[31] = iv[30];  // Useg or kseg2/3.
        dv     = {19'h00200, dv[12:0]};
        translate_check("random_mapped", iv, dv, 8'h11, 1'b0);
    end
endtask

task automatic test_probe();
    cp0_entrylo_t lo0;
    cp0_entrylo_t lo1;
    lo0 = {6'd0, 20'h11111, 3'd3, 1'b1, 1'b1, 1'b0};
    lo1 = {6'd0, 20'h22222, 3'd3, 1'b1, 1'b1, 1'b0};
    probe_check("probe_hit", {19'h00200, 5'd0, 8'h11});
    probe_check("probe_global", {19'h60001, 5'd0, 8'h44});
    probe_check("probe_asid_miss", {19'h00200, 5'd0, 8'h44});
    // Same page and ASID twice, entry 4 wins.
    tlb_write(10, {19'h00300, 5'd0, 8'h55}, lo0, lo1);
    lo0.pfn = 20'h33333;
    lo1.pfn = 20'h44444;
    tlb_write(4, {19'h00300, 5'd0, 8'h55}, lo0, lo1);
    probe_check("probe_duplicate", {19'h00300, 5'd0, 8'h55});
    translate_check("dup_translate", 32'h0060_0444, 32'h0060_1444, 8'h55, 1'b0);
endtask

// ==== verif/tu_tb.sv ====
module tu_tb import tu_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;

    logic          clk;
    logic          resetn;
    logic          k0_uncached;
    tu_addr_req_t  ireq;
    tu_addr_req_t  dreq;
    tu_op_req_t    op_req;
    tu_addr_resp_t iresp;
    tu_addr_resp_t dresp;
    tu_op_resp_t   op_resp;

    int     mismatches = 0;
    int     failures   = 0;
    int     cycles     = 0;
    integer seed       = 30;

    translation_unit UUT (
        .clk           (clk),
        .resetn        (resetn),
        .i_k0_uncached (k0_uncached),
        .i_ireq        (ireq),
        .i_dreq        (dreq),
        .i_op_req      (op_req),
        .o_iresp       (iresp),
        .o_dresp       (dresp),
        .o_op_resp     (op_resp)
    );

    `include "tu_tests.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Ends a stuck run.
    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: tests still running after %0d cycles", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        resetn      = 1'b0;
        k0_uncached = 1'b0;
        ireq        = '0;
        dreq        = '0;
        op_req      = '0;
        model_clear();
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        test_reset_state();
        test_unmapped();
        test_write_read();
        test_mapped();
        test_probe();

        $display("Finished after %0d cycles: %0d mismatches, %0d other errors",
                 cycles, mismatches, failures);
        if ((mismatches + failures) == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verif
logic/tu_pkg.sv
logic/seg_decode.sv
logic/tlb_table.sv
logic/tlb_lookup.sv
logic/translation_unit.sv
verif/tu_tb.sv
